// File: build.f
source/dm_reg_pkg.sv
source/dmi_pkg.sv
source/dmi_resp_fifo.sv
source/hart_ctrl.sv
source/abstract_cmd_regs.sv
source/dm_regfile.sv
sim/tb_dm_regfile.sv

// File: run.sh
#!/bin/sh
# build with Verilator and run; the exit status is the simulation result
verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_dm_regfile -o tb_dm_regfile \
  && ./obj_dir/tb_dm_regfile \
  || exit 1

// File: sim/tb_dm_regfile.sv
/*
 * Random-stimulus testbench for the debug module register file. Drives
 * DMI requests and hart and command side inputs, keeps a register model
 * and compares every response and control output against it.
 */

`timescale 1ns/1ns

module tb_dm_regfile
  import dmi_pkg::*;
  import dm_reg_pkg::*;
();

  localparam int NrHarts     = 4;
  localparam int DataCount   = 2;
  localparam int ProgBufSize = 4;

  logic clk_i, rst_ni;
  logic dmi_req_valid_i, dmi_req_ready_o, dmi_resp_valid_o, dmi_resp_ready_i;
  dmi_req_t  dmi_req_i;
  dmi_resp_t dmi_resp_o;
  logic [NrHarts-1:0] halted_i, unavailable_i, resumeack_i, haltreq_o, resumereq_o;
  logic clear_resumeack_o, ndmreset_o, dmactive_o, cmd_valid_o;
  logic [19:0] hartsel_o;
  command_t cmd_o;
  logic cmdbusy_i, cmderror_valid_i, data_valid_i;
  cmderr_e cmderror_i;
  logic [DataCount-1:0][31:0]   data_i, data_o;
  logic [ProgBufSize-1:0][31:0] progbuf_o;

  // model state
  logic m_dmactive, m_ndmreset, m_haltreq, m_resumereq;
  logic [19:0] m_hartsel;
  logic [NrHarts-1:0] m_havereset;
  logic [31:0] m_data [DataCount];
  logic [31:0] m_progbuf [ProgBufSize];
  logic [DataCount-1:0] m_auto_data;
  logic [ProgBufSize-1:0] m_auto_pb;
  logic [31:0] m_command;
  logic [2:0] m_cmderr;
  logic [31:0] exp_q [$];
  logic [31:0] rng_q, bp_rng_q;
  int bp_mode;

  dm_regfile #(
    .NrHarts     (NrHarts),
    .DataCount   (DataCount),
    .ProgBufSize (ProgBufSize)
  ) dut0 (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_q = xorshift32(rng_q);
    return rng_q;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  // ----------------------------------------
  // register model
  // ----------------------------------------
  function automatic logic [31:0] make_ctrl(logic hreq, logic rreq, logic ack,
                                            logic [19:0] sel, logic ndm, logic act);
    return {hreq, rreq, 1'b0, ack, 2'b0, sel[9:0], sel[19:10], 4'b0, ndm, act};
  endfunction

  function automatic void clear_abstract();
    for (int i = 0; i < DataCount; i++) m_data[i] = '0;
    for (int i = 0; i < ProgBufSize; i++) m_progbuf[i] = '0;
    m_auto_data = '0;
    m_auto_pb   = '0;
    m_command   = '0;
    m_cmderr    = '0;
  endfunction

  function automatic logic [NrHarts-1:0] sel_bits(input logic en);
    logic [NrHarts-1:0] v;
    v = '0;
    if (en && m_hartsel < NrHarts) v[m_hartsel] = 1'b1;
    return v;
  endfunction

  function automatic logic [31:0] model_read(input logic [6:0] addr);
    logic [31:0] r;
    logic ok, hl, un, ra, hr;
    int di, pi;
    r  = '0;
    di = int'(addr) - 4;
    pi = int'(addr) - 32;
    ok = m_hartsel < NrHarts;
    hl = ok ? halted_i[m_hartsel] : 1'b0;
    un = ok ? unavailable_i[m_hartsel] : 1'b0;
    ra = ok ? resumeack_i[m_hartsel] : 1'b0;
    hr = ok ? m_havereset[m_hartsel] : 1'b0;
    if (di >= 0 && di < DataCount) r = m_data[di];
    else if (pi >= 0 && pi < ProgBufSize) r = m_progbuf[pi];
    else if (addr == DMControl) begin
      r = make_ctrl(m_haltreq, m_resumereq, 1'b0, m_hartsel, m_ndmreset, m_dmactive);
    end else if (addr == DMStatus) begin
      // version 2 and authenticated below the any/all pairs
      r = 32'h82;
      r[9:8]   = {2{hl & ~un}};
      r[11:10] = {2{ok & ~hl & ~un}};
      r[13:12] = {2{un}};
      r[15:14] = {2{~ok}};
      r[17:16] = {2{ra}};
      r[19:18] = {2{hr}};
    end else if (addr == HaltSum0) begin
      if (m_hartsel[19:5] == 0) r[NrHarts-1:0] = halted_i;
    end else if (addr == AbstractCS) begin
      r = {3'b0, 5'(ProgBufSize), 11'b0, cmdbusy_i, 1'b0, m_cmderr, 4'b0, 4'(DataCount)};
    end else if (addr == AbstractAuto) begin
      r[DataCount-1:0]          = m_auto_data;
      r[16 +: ProgBufSize]      = m_auto_pb;
    end
    return r;
  endfunction

  // updates the model and returns whether a command is launched
  function automatic logic apply_access(input dtm_op_e op, input logic [6:0] addr,
                                        input logic [31:0] w);
    logic act_old, rd, wr, trig, busy_err;
    int di, pi;
    act_old  = m_dmactive;
    rd       = (op == DTM_READ);
    wr       = (op == DTM_WRITE);
    trig     = 1'b0;
    busy_err = 1'b0;
    di       = int'(addr) - 4;
    pi       = int'(addr) - 32;
    if (wr && addr == DMControl) begin
      if (w[28] && m_hartsel < NrHarts) m_havereset[m_hartsel] = 1'b0;
      if (m_ndmreset) m_havereset = '1;
      if (act_old) begin
        m_haltreq   = w[31];
        m_resumereq = w[30];
        m_hartsel   = {w[15:6], w[25:16]};
        m_ndmreset  = w[1];
        m_dmactive  = w[0];
        if (w[1]) m_havereset = '1;
      end else begin
        m_dmactive = w[0];
      end
    end
    if (act_old && (rd || wr)) begin
      if (di >= 0 && di < DataCount) begin
        if (cmdbusy_i) busy_err = wr;
        else begin
          if (wr) m_data[di] = w;
          trig = m_auto_data[di];
        end
      end else if (pi >= 0 && pi < ProgBufSize) begin
        if (cmdbusy_i) busy_err = wr;
        else begin
          if (wr) m_progbuf[pi] = w;
          trig = m_auto_pb[pi];
        end
      end else if (wr && addr == Command) begin
        if (cmdbusy_i) busy_err = 1'b1;
        else begin
          m_command = w;
          trig      = 1'b1;
        end
      end else if (wr && addr == AbstractAuto) begin
        if (cmdbusy_i) busy_err = 1'b1;
        else begin
          m_auto_data = w[DataCount-1:0];
          m_auto_pb   = w[16 +: ProgBufSize];
        end
      end else if (wr && addr == AbstractCS && !cmdbusy_i) begin
        m_cmderr = m_cmderr & ~w[10:8];
      end
    end
    if (busy_err && m_cmderr == 3'd0) m_cmderr = 3'd1;
    if (act_old && !m_dmactive) clear_abstract();
    return trig;
  endfunction

  // ----------------------------------------
  // stimulus and response checking
  // ----------------------------------------
  task automatic dmi_access(input dtm_op_e op, input logic [6:0] addr,
                            input logic [31:0] wdata);
    int waited;
    logic trig, exp_clr;
    @(negedge clk_i);
    dmi_req_valid_i = 1'b1;
    dmi_req_i       = '{addr: addr, data: wdata, op: op};
    #1;
    waited = 0;
    while (!dmi_req_ready_o) begin
      waited++;
      if (waited > 100) fail_timeout("request ready");
      @(negedge clk_i);
      #1;
    end
    exp_q.push_back((op == DTM_READ) ? model_read(addr) : 32'h0);
    exp_clr = (op == DTM_WRITE) && (addr == DMControl) && m_dmactive && !m_resumereq
              && wdata[30];
    check_value("clear_resumeack_o", 32'(clear_resumeack_o), 32'(exp_clr));
    trig = apply_access(op, addr, wdata);
    @(negedge clk_i);
    dmi_req_valid_i = 1'b0;
    check_value("cmd_valid_o", 32'(cmd_valid_o), 32'(trig));
    if (trig) check_value("cmd_o", cmd_o, m_command);
    check_value("haltreq_o", 32'(haltreq_o), 32'(sel_bits(m_haltreq)));
    check_value("resumereq_o", 32'(resumereq_o), 32'(sel_bits(m_resumereq)));
    check_value("dmactive_o", 32'(dmactive_o), 32'(m_dmactive));
    check_value("hartsel_o", 32'(hartsel_o), 32'(m_hartsel));
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || dmi_resp_valid_o) begin
      waited++;
      if (waited > 200) fail_timeout("outstanding responses");
      @(negedge clk_i);
    end
  endtask

  // response ready and in-order comparison
  always @(negedge clk_i) begin
    if (rst_ni) begin
      bp_rng_q = xorshift32(bp_rng_q);
      dmi_resp_ready_i = (bp_mode == 0) || (bp_mode == 1 && bp_rng_q[3]);
      if (dmi_resp_valid_o && dmi_resp_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("a response arrived without an outstanding request");
          $display("Simulation FAILED");
          $fatal(1);
        end
        check_value("response data", dmi_resp_o.data, exp_q.pop_front());
        check_value("response code", 32'(dmi_resp_o.resp), 32'h0);
      end
    end
  end

  initial begin
    int waited;
    logic [6:0] a;
    logic [19:0] sel;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    rng_q = 32'he37f_5643;
    bp_rng_q = ~rng_q;
    bp_mode = 0;
    dmi_req_valid_i = 1'b0;
    dmi_req_i = '0;
    dmi_resp_ready_i = 1'b0;
    halted_i = 4'b0101;
    unavailable_i = '0;
    resumeack_i = '0;
    cmdbusy_i = 1'b0;
    cmderror_valid_i = 1'b0;
    cmderror_i = CmdErrNone;
    data_valid_i = 1'b0;
    data_i = '0;
    m_dmactive = 0;
    m_ndmreset = 0;
    m_haltreq = 0;
    m_resumereq = 0;
    m_hartsel = '0;
    m_havereset = '1;
    clear_abstract();
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_value("ready after reset", 32'(dmi_req_ready_o), 32'h1);
    check_value("outputs after reset", 32'({dmi_resp_valid_o, cmd_valid_o, haltreq_o,
                resumereq_o, ndmreset_o, dmactive_o, clear_resumeack_o}), 32'h0);
    dmi_access(DTM_READ, DMStatus, '0);
    dmi_access(DTM_WRITE, Data0, next_random());
    dmi_access(DTM_READ, Data0, '0);
    dmi_access(DTM_WRITE, DMControl, make_ctrl(0, 0, 0, '0, 0, 1));

    // data and program buffer
    repeat (40) begin
      a = (next_random() % 2 == 0) ? 7'(4 + next_random() % DataCount)
                                   : 7'(32 + next_random() % ProgBufSize);
      dmi_access(next_random() % 2 ? DTM_WRITE : DTM_READ, a, next_random());
    end
    @(negedge clk_i);
    data_i = {next_random(), next_random()};
    data_valid_i = 1'b1;
    @(negedge clk_i);
    data_valid_i = 1'b0;
    for (int i = 0; i < DataCount; i++) m_data[i] = data_i[i];
    for (int i = 0; i < DataCount; i++) begin
      check_value("data_o", data_o[i], m_data[i]);
      dmi_access(DTM_READ, 7'(4 + i), '0);
    end

    // abstract commands
    dmi_access(DTM_WRITE, Command, next_random());
    dmi_access(DTM_WRITE, AbstractAuto, next_random() | 32'h0002_0001);
    dmi_access(DTM_READ, Data0, '0);
    cmdbusy_i = 1'b1;
    dmi_access(DTM_WRITE, Command, next_random());
    dmi_access(DTM_READ, AbstractCS, '0);
    cmdbusy_i = 1'b0;
    dmi_access(DTM_WRITE, AbstractCS, 32'h0000_0700);
    dmi_access(DTM_READ, AbstractCS, '0);
    @(negedge clk_i);
    cmderror_valid_i = 1'b1;
    cmderror_i = CmdErrException;
    @(negedge clk_i);
    cmderror_valid_i = 1'b0;
    m_cmderr = 3'(CmdErrException);
    dmi_access(DTM_READ, AbstractCS, '0);
    repeat (40) begin
      cmdbusy_i = next_random() % 4 == 0;
      case (next_random() % 5)
        0: a = 7'(4 + next_random() % DataCount);
        1: a = 7'(32 + next_random() % ProgBufSize);
        2: a = Command;
        3: a = AbstractAuto;
        default: a = AbstractCS;
      endcase
      dmi_access(next_random() % 2 ? DTM_WRITE : DTM_READ, a, next_random());
    end
    cmdbusy_i = 1'b0;
    for (int i = 0; i < ProgBufSize; i++) check_value("progbuf_o", progbuf_o[i], m_progbuf[i]);

    // hart control
    repeat (30) begin
      halted_i = NrHarts'(next_random());
      unavailable_i = NrHarts'(next_random());
      resumeack_i = NrHarts'(next_random());
      sel = next_random() % 4 == 0 ? 20'(32 + next_random() % 8) : 20'(next_random() % 8);
      dmi_access(DTM_WRITE, DMControl, make_ctrl(next_random() % 2, 0, 0, sel, 0, 1));
      dmi_access(DTM_READ, DMStatus, '0);
      dmi_access(DTM_READ, HaltSum0, '0);
      dmi_access(DTM_READ, DMControl, '0);
    end
    resumeack_i = '0;
    dmi_access(DTM_WRITE, DMControl, make_ctrl(0, 1, 0, 20'd1, 0, 1));
    resumeack_i = 4'b0010;
    waited = 0;
    while (resumereq_o != '0) begin
      waited++;
      if (waited > 50) fail_timeout("resumereq to clear");
      @(negedge clk_i);
    end
    m_resumereq = 1'b0;
    resumeack_i = '0;
    dmi_access(DTM_WRITE, DMControl, make_ctrl(0, 0, 0, 20'd2, 0, 1));
    dmi_access(DTM_WRITE, DMControl, make_ctrl(0, 0, 1, 20'd2, 0, 1));
    dmi_access(DTM_READ, DMStatus, '0);
    dmi_access(DTM_WRITE, DMControl, make_ctrl(0, 0, 0, 20'd2, 1, 1));
    check_value("ndmreset_o", 32'(ndmreset_o), 32'h1);
    dmi_access(DTM_WRITE, DMControl, make_ctrl(0, 0, 0, 20'd2, 0, 1));
    dmi_access(DTM_READ, DMStatus, '0);

    // back-pressure
    bp_mode = 1;
    repeat (30) begin
      a = (next_random() % 2) ? DMStatus : 7'(4 + next_random() % DataCount);
      dmi_access(next_random() % 4 == 0 ? DTM_NOP : DTM_READ, a, '0);
    end
    bp_mode = 0;
    wait_drained();
    bp_mode = 2;
    dmi_access(DTM_READ, DMControl, '0);
    dmi_access(DTM_READ, AbstractCS, '0);
    check_value("ready with two outstanding", 32'(dmi_req_ready_o), 32'h0);
    bp_mode = 0;
    wait_drained();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: source/dm_regfile.sv
/*
 * Debug module register file, top level. Accepts DMI requests, turns them
 * into register accesses for the hart control and abstract command blocks,
 * and queues the read data as DMI responses.
 */

`timescale 1ns/1ns

module dm_regfile
  import dmi_pkg::*;
  import dm_reg_pkg::*;
#(
  parameter int unsigned NrHarts     = 4,
  parameter int unsigned DataCount   = 2,
  parameter int unsigned ProgBufSize = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // DMI port
  input  logic                         dmi_req_valid_i,
  input  dmi_req_t                     dmi_req_i,
  output logic                         dmi_req_ready_o,
  output logic                         dmi_resp_valid_o,
  input  logic                         dmi_resp_ready_i,
  output dmi_resp_t                    dmi_resp_o,
  // hart side
  input  logic [NrHarts-1:0]           halted_i,
  input  logic [NrHarts-1:0]           unavailable_i,
  input  logic [NrHarts-1:0]           resumeack_i,
  output logic [NrHarts-1:0]           haltreq_o,
  output logic [NrHarts-1:0]           resumereq_o,
  output logic                         clear_resumeack_o,
  output logic                         ndmreset_o,
  output logic                         dmactive_o,
  output logic [19:0]                  hartsel_o,
  // command side
  output logic                         cmd_valid_o,
  output command_t                     cmd_o,
  input  logic                         cmdbusy_i,
  input  logic                         cmderror_valid_i,
  input  cmderr_e                      cmderror_i,
  input  logic                         data_valid_i,
  input  logic [DataCount-1:0][31:0]   data_i,
  output logic [DataCount-1:0][31:0]   data_o,
  output logic [ProgBufSize-1:0][31:0] progbuf_o
);

  reg_acc_t    acc;
  logic        accept;
  logic        fifo_full, fifo_empty;
  logic [31:0] hart_rdata, abs_rdata;

  // ----------------------------------------
  // request side
  // ----------------------------------------
  assign dmi_req_ready_o = ~fifo_full;
  assign accept          = dmi_req_valid_i & dmi_req_ready_o;

  assign acc.rd    = accept & (dmi_req_i.op == DTM_READ);
  assign acc.wr    = accept & (dmi_req_i.op == DTM_WRITE);
  assign acc.addr  = dm_csr_e'(dmi_req_i.addr);
  assign acc.wdata = dmi_req_i.data;

  hart_ctrl #(
    .NrHarts (NrHarts)
  ) u_hart_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .acc_i             (acc),
    .rdata_o           (hart_rdata),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive_o),
    .hartsel_o         (hartsel_o)
  );

  abstract_cmd_regs #(
    .DataCount   (DataCount),
    .ProgBufSize (ProgBufSize)
  ) u_abstract_cmd_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .acc_i            (acc),
    .dmactive_i       (dmactive_o),
    .rdata_o          (abs_rdata),
    .cmdbusy_i        (cmdbusy_i),
    .cmderror_valid_i (cmderror_valid_i),
    .cmderror_i       (cmderror_i),
    .data_valid_i     (data_valid_i),
    .data_i           (data_i),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_o            (cmd_o),
    .data_o           (data_o),
    .progbuf_o        (progbuf_o)
  );

  // ----------------------------------------
  // response side
  // ----------------------------------------
  // unowned addresses, writes and nops read as zero in both blocks
  dmi_resp_fifo u_resp_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (accept),
    .data_i  (hart_rdata | abs_rdata),
    .full_o  (fifo_full),
    .empty_o (fifo_empty),
    .pop_i   (dmi_resp_ready_i & ~fifo_empty),
    .data_o  (dmi_resp_o.data)
  );

  assign dmi_resp_valid_o = ~fifo_empty;
  assign dmi_resp_o.resp  = DTM_SUCCESS;

endmodule

// File: source/abstract_cmd_regs.sv
/*
 * Abstract command block: command, abstractcs with cmderr, abstractauto,
 * the data words and the program buffer. Raises cmd_valid_o for a command
 * write or an autoexec access while the executor is idle.
 */

`timescale 1ns/1ns

module abstract_cmd_regs
  import dmi_pkg::*;
  import dm_reg_pkg::*;
#(
  parameter int unsigned DataCount   = 2,
  parameter int unsigned ProgBufSize = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  reg_acc_t                         acc_i,
  input  logic                             dmactive_i,
  output logic [31:0]                      rdata_o,
  input  logic                             cmdbusy_i,
  input  logic                             cmderror_valid_i,
  input  cmderr_e                          cmderror_i,
  input  logic                             data_valid_i,
  input  logic [DataCount-1:0][31:0]       data_i,
  output logic                             cmd_valid_o,
  output command_t                         cmd_o,
  output logic [DataCount-1:0][31:0]       data_o,
  output logic [ProgBufSize-1:0][31:0]     progbuf_o
);

  localparam int unsigned DIdxW = (DataCount > 1) ? $clog2(DataCount) : 1;
  localparam int unsigned PIdxW = (ProgBufSize > 1) ? $clog2(ProgBufSize) : 1;

  cmderr_e                      cmderr_d, cmderr_q;
  command_t                     command_d, command_q;
  logic                         cmd_valid_d, cmd_valid_q;
  logic [DataCount-1:0]         auto_data_d, auto_data_q;
  logic [ProgBufSize-1:0]       auto_pb_d, auto_pb_q;
  logic [DataCount-1:0][31:0]   data_d, data_q;
  logic [ProgBufSize-1:0][31:0] progbuf_d, progbuf_q;
  abstractcs_t                  abstractcs, acs_wr;
  logic [6:0]                   data_off, pb_off;
  logic [DIdxW-1:0]             data_idx;
  logic [PIdxW-1:0]             pb_idx;
  logic                         data_hit, pb_hit, acc_any, busy_err;

  // addresses below the base wrap around and miss
  assign data_off = acc_i.addr - Data0;
  assign pb_off   = acc_i.addr - ProgBuf0;
  assign data_hit = (data_off < 7'(DataCount));
  assign pb_hit   = (pb_off < 7'(ProgBufSize));
  assign data_idx = data_off[DIdxW-1:0];
  assign pb_idx   = pb_off[PIdxW-1:0];
  assign acc_any  = acc_i.rd | acc_i.wr;
  assign acs_wr   = abstractcs_t'(acc_i.wdata);

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;
  assign progbuf_o   = progbuf_q;

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    cmderr_d    = cmderr_q;
    command_d   = command_q;
    cmd_valid_d = 1'b0;
    auto_data_d = auto_data_q;
    auto_pb_d   = auto_pb_q;
    data_d      = data_q;
    progbuf_d   = progbuf_q;
    busy_err    = 1'b0;

    // data and progbuf, autoexec retriggers on read or write
    if (acc_any && data_hit) begin
      if (cmdbusy_i) begin
        busy_err = acc_i.wr;
      end else begin
        if (acc_i.wr) begin
          data_d[data_idx] = acc_i.wdata;
        end
        cmd_valid_d = auto_data_q[data_idx];
      end
    end else if (acc_any && pb_hit) begin
      if (cmdbusy_i) begin
        busy_err = acc_i.wr;
      end else begin
        if (acc_i.wr) begin
          progbuf_d[pb_idx] = acc_i.wdata;
        end
        cmd_valid_d = auto_pb_q[pb_idx];
      end
    end else if (acc_i.wr) begin
      case (acc_i.addr)
        Command: begin
          if (cmdbusy_i) begin
            busy_err = 1'b1;
          end else begin
            command_d   = command_t'(acc_i.wdata);
            cmd_valid_d = 1'b1;
          end
        end
        AbstractAuto: begin
          if (cmdbusy_i) begin
            busy_err = 1'b1;
          end else begin
            auto_data_d = acc_i.wdata[DataCount-1:0];
            auto_pb_d   = acc_i.wdata[16 +: ProgBufSize];
          end
        end
        AbstractCS: begin
          // cmderr is write-1-to-clear
          if (!cmdbusy_i) begin
            cmderr_d = cmderr_e'(cmderr_q & ~acs_wr.cmderr);
          end
        end
        default: ;
      endcase
    end

    if (busy_err && cmderr_q == CmdErrNone) begin
      cmderr_d = CmdErrBusy;
    end
    // executor errors win over debugger writes
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end
  end

  // ----------------------------------------
  // registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q    <= CmdErrNone;
      cmd_valid_q <= 1'b0;
      auto_data_q <= '0;
      auto_pb_q   <= '0;
    end else if (!dmactive_i) begin
      cmderr_q    <= CmdErrNone;
      cmd_valid_q <= 1'b0;
      auto_data_q <= '0;
      auto_pb_q   <= '0;
    end else begin
      cmderr_q    <= cmderr_d;
      cmd_valid_q <= cmd_valid_d;
      auto_data_q <= auto_data_d;
      auto_pb_q   <= auto_pb_d;
    end
  end

  // payload, cleared while the module is inactive
  always_ff @(posedge clk_i) begin
    if (!dmactive_i) begin
      command_q <= '0;
      data_q    <= '0;
      progbuf_q <= '0;
    end else begin
      command_q <= command_d;
      data_q    <= data_d;
      progbuf_q <= progbuf_d;
    end
  end

  // ----------------------------------------
  // read back
  // ----------------------------------------
  always_comb begin
    abstractcs             = '0;
    abstractcs.datacount   = 4'(DataCount);
    abstractcs.progbufsize = 5'(ProgBufSize);
    abstractcs.busy        = cmdbusy_i;
    abstractcs.cmderr      = cmderr_q;
    rdata_o                = '0;
    if (acc_i.rd) begin
      if (data_hit) begin
        rdata_o = data_q[data_idx];
      end else if (pb_hit) begin
        rdata_o = progbuf_q[pb_idx];
      end else if (acc_i.addr == AbstractCS) begin
        rdata_o = abstractcs;
      end else if (acc_i.addr == AbstractAuto) begin
        rdata_o[DataCount-1:0]    = auto_data_q;
        rdata_o[16 +: ProgBufSize] = auto_pb_q;
      end
    end
  end

  // executor must raise cmdbusy_i before the next command can start
  a_cmd_valid_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_ni) cmd_valid_o |=> !cmd_valid_o
  );

endmodule

// File: source/hart_ctrl.sv
/*
 * Hart control registers: dmcontrol, the havereset flags, the halt and
 * resume requests to the selected hart, and the read-only dmstatus and
 * haltsum0 views of the hart status inputs.
 */

`timescale 1ns/1ns

module hart_ctrl
  import dmi_pkg::*;
  import dm_reg_pkg::*;
#(
  parameter int unsigned NrHarts = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  reg_acc_t           acc_i,
  output logic [31:0]        rdata_o,
  input  logic [NrHarts-1:0] halted_i,
  input  logic [NrHarts-1:0] unavailable_i,
  input  logic [NrHarts-1:0] resumeack_i,
  output logic [NrHarts-1:0] haltreq_o,
  output logic [NrHarts-1:0] resumereq_o,
  output logic               clear_resumeack_o,
  output logic               ndmreset_o,
  output logic               dmactive_o,
  output logic [19:0]        hartsel_o
);

  dmcontrol_t         dmcontrol_d, dmcontrol_q;
  dmcontrol_t         wr_ctrl;
  dmstatus_t          dmstatus;
  logic [31:0]        haltsum0;
  logic [NrHarts-1:0] havereset_d, havereset_q;
  logic [NrHarts-1:0] sel_onehot;
  logic               sel_valid;
  logic               sel_halted, sel_unavail, sel_resumeack, sel_havereset;

  assign hartsel_o  = {dmcontrol_q.hartselhi, dmcontrol_q.hartsello};
  assign dmactive_o = dmcontrol_q.dmactive;
  assign ndmreset_o = dmcontrol_q.ndmreset;

  // ----------------------------------------
  // hart selection
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < NrHarts; i++) begin
      sel_onehot[i] = (hartsel_o == 20'(i));
    end
  end

  // hartsel beyond the last hart selects nothing
  assign sel_valid     = |sel_onehot;
  assign sel_halted    = |(halted_i & sel_onehot);
  assign sel_unavail   = |(unavailable_i & sel_onehot);
  assign sel_resumeack = |(resumeack_i & sel_onehot);
  assign sel_havereset = |(havereset_q & sel_onehot);

  assign haltreq_o   = sel_onehot & {NrHarts{dmcontrol_q.haltreq}};
  assign resumereq_o = sel_onehot & {NrHarts{dmcontrol_q.resumereq}};

  // ----------------------------------------
  // dmcontrol and havereset update
  // ----------------------------------------
  always_comb begin
    dmcontrol_d = dmcontrol_q;
    havereset_d = havereset_q;
    wr_ctrl     = dmcontrol_t'(acc_i.wdata);
    if (acc_i.wr && acc_i.addr == DMControl) begin
      // only a few fields are writable, the rest stays zero
      dmcontrol_d           = '0;
      dmcontrol_d.haltreq   = wr_ctrl.haltreq;
      dmcontrol_d.resumereq = wr_ctrl.resumereq;
      dmcontrol_d.hartsello = wr_ctrl.hartsello;
      dmcontrol_d.hartselhi = wr_ctrl.hartselhi;
      dmcontrol_d.ndmreset  = wr_ctrl.ndmreset;
      dmcontrol_d.dmactive  = wr_ctrl.dmactive;
      if (wr_ctrl.ackhavereset) begin
        havereset_d = havereset_d & ~sel_onehot;
      end
    end
    // rising resumereq starts a new handshake
    clear_resumeack_o = dmcontrol_q.dmactive & ~dmcontrol_q.resumereq
                        & dmcontrol_d.resumereq;
    if (dmcontrol_q.resumereq && sel_resumeack) begin
      dmcontrol_d.resumereq = 1'b0;
    end
    // a system reset marks every hart
    if (dmcontrol_q.ndmreset) begin
      havereset_d = '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
      havereset_q <= '1;
    end else begin
      havereset_q <= havereset_d;
      if (dmcontrol_q.dmactive) begin
        dmcontrol_q <= dmcontrol_d;
      end else begin
        // inactive module, only dmactive can be set
        dmcontrol_q <= dmcontrol_t'({31'b0, dmcontrol_d.dmactive});
      end
    end
  end

  // ----------------------------------------
  // read-only views
  // ----------------------------------------
  always_comb begin
    dmstatus                = '0;
    dmstatus.version        = DbgVersion013;
    dmstatus.authenticated  = 1'b1;
    dmstatus.allhalted      = sel_halted & ~sel_unavail;
    dmstatus.anyhalted      = sel_halted & ~sel_unavail;
    dmstatus.allrunning     = sel_valid & ~sel_halted & ~sel_unavail;
    dmstatus.anyrunning     = sel_valid & ~sel_halted & ~sel_unavail;
    dmstatus.allunavail     = sel_unavail;
    dmstatus.anyunavail     = sel_unavail;
    dmstatus.allnonexistent = ~sel_valid;
    dmstatus.anynonexistent = ~sel_valid;
    dmstatus.allresumeack   = sel_resumeack;
    dmstatus.anyresumeack   = sel_resumeack;
    dmstatus.allhavereset   = sel_havereset;
    dmstatus.anyhavereset   = sel_havereset;
  end

  // haltsum0 covers harts 0..31 only
  always_comb begin
    haltsum0 = '0;
    if (hartsel_o[19:5] == 15'd0) begin
      haltsum0[NrHarts-1:0] = halted_i;
    end
  end

  always_comb begin
    rdata_o = '0;
    if (acc_i.rd) begin
      case (acc_i.addr)
        DMControl: rdata_o = dmcontrol_q;
        DMStatus:  rdata_o = dmstatus;
        HaltSum0:  rdata_o = haltsum0;
        default:   rdata_o = '0;
      endcase
    end
  end

  a_haltreq_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(haltreq_o)
  );

endmodule

// File: source/dmi_resp_fifo.sv
/*
 * Two-entry response queue between the register file and the debugger.
 * The register file pushes one word per accepted request and the
 * debugger pops them in order.
 */

`timescale 1ns/1ns

module dmi_resp_fifo (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        push_i,
  input  logic [31:0] data_i,
  output logic        full_o,
  output logic        empty_o,
  input  logic        pop_i,
  output logic [31:0] data_o
);

  logic [1:0][31:0] mem_q;
  logic             wr_ptr_q;
  logic             rd_ptr_q;
  logic [1:0]       count_q;

  assign full_o  = (count_q == 2'd2);
  assign empty_o = (count_q == 2'd0);
  assign data_o  = mem_q[rd_ptr_q];

  // pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop_i) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + 2'(push_i) - 2'(pop_i);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // the writer must respect full, the reader must respect empty
  a_no_push_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni) full_o |-> !push_i
  );
  a_no_pop_empty : assert property (
    @(posedge clk_i) disable iff (!rst_ni) empty_o |-> !pop_i
  );

endmodule

// File: source/dmi_pkg.sv
/*
 * Transport types of the debug module interface: the operation codes,
 * the request and response words of the DMI port, and the access record
 * that the top level hands to the register blocks.
 */

package dmi_pkg;

  import dm_reg_pkg::*;

  // DMI operation field
  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2
  } dtm_op_e;

  // result code returned with every response
  localparam logic [1:0] DTM_SUCCESS = 2'h0;

  // one request from the debugger
  typedef struct packed {
    logic [6:0]  addr;
    logic [31:0] data;
    dtm_op_e     op;
  } dmi_req_t;

  // one response back to the debugger
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } dmi_resp_t;

  // accepted access as the register blocks see it
  typedef struct packed {
    logic        rd;
    logic        wr;
    dm_csr_e     addr;
    logic [31:0] wdata;
  } reg_acc_t;

endpackage

// File: source/dm_reg_pkg.sv
/*
 * Register map of the debug module: CSR addresses, the bit layouts of
 * dmcontrol, dmstatus, abstractcs and command, and the abstract command
 * error codes. Shared by the register blocks and the top level.
 */

package dm_reg_pkg;

  // dmstatus.version for spec 0.13
  localparam logic [3:0] DbgVersion013 = 4'h2;

  typedef enum logic [6:0] {
    Data0        = 7'h04,
    DMControl    = 7'h10,
    DMStatus     = 7'h11,
    AbstractCS   = 7'h16,
    Command      = 7'h17,
    AbstractAuto = 7'h18,
    ProgBuf0     = 7'h20,
    HaltSum0     = 7'h40
  } dm_csr_e;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'h0,
    CmdErrBusy         = 3'h1,
    CmdErrNotSupported = 3'h2,
    CmdErrException    = 3'h3,
    CmdErrHaltResume   = 3'h4,
    CmdErrBus          = 3'h5,
    CmdErrOther        = 3'h7
  } cmderr_e;

  typedef struct packed {
    logic       haltreq;
    logic       resumereq;
    logic       hartreset;
    logic       ackhavereset;
    logic       zero1;
    logic       hasel;
    logic [9:0] hartsello;
    logic [9:0] hartselhi;
    logic [1:0] zero0;
    logic       setresethaltreq;
    logic       clrresethaltreq;
    logic       ndmreset;
    logic       dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [8:0] zero1;
    logic       impebreak;
    logic [1:0] zero0;
    logic       allhavereset;
    logic       anyhavereset;
    logic       allresumeack;
    logic       anyresumeack;
    logic       allnonexistent;
    logic       anynonexistent;
    logic       allunavail;
    logic       anyunavail;
    logic       allrunning;
    logic       anyrunning;
    logic       allhalted;
    logic       anyhalted;
    logic       authenticated;
    logic       authbusy;
    logic       hasresethaltreq;
    logic       confstrptrvalid;
    logic [3:0] version;
  } dmstatus_t;

  typedef struct packed {
    logic [2:0]  zero3;
    logic [4:0]  progbufsize;
    logic [10:0] zero2;
    logic        busy;
    logic        zero1;
    cmderr_e     cmderr;
    logic [3:0]  zero0;
    logic [3:0]  datacount;
  } abstractcs_t;

  typedef struct packed {
    logic [7:0]  cmdtype;
    logic [23:0] control;
  } command_t;

endpackage
